// File: tb.f
trace_pkg.sv
trace_decoder.sv
trace_issue.sv
trace_ex_track.sv
trace_wb_retire.sv
instr_tracer.sv
instr_tracer_properties.sv
tb_instr_tracer.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_instr_tracer
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) -f $(FILELIST)
LINTFLAGS := --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)
SIMARGS   := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIMARGS) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_instr_tracer.sv
//////////////////////////////
// tb_instr_tracer
// clock, reset and in-order core model
// random instruction stimulus from a table
// watchdog and closing report
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_instr_tracer;

  import trace_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int N_INSTR    = 300;
  localparam int SEED       = 60382;
  localparam int TIMEOUT_NS = N_INSTR * 8 * CLK_PERIOD;

  // table entry with the word and how the core treats it
  typedef struct packed {
    logic [XLEN-1:0] word;
    logic            writer;
    logic            mem;
    logic            store;
  } op_t;

  logic                  clk;
  logic                  rst_n;
  logic [XLEN-1:0]       pc;
  logic [XLEN-1:0]       instr;
  logic                  id_valid;
  logic                  is_decoding;
  logic                  pipe_flush;
  logic                  ex_valid;
  logic [REG_ADDR_W-1:0] ex_reg_addr;
  logic                  ex_reg_we;
  logic [XLEN-1:0]       ex_reg_wdata;
  logic                  ex_data_req;
  logic                  ex_data_gnt;
  logic                  ex_data_we;
  logic [XLEN-1:0]       ex_data_addr;
  logic                  wb_valid;
  logic [REG_ADDR_W-1:0] wb_reg_addr;
  logic                  wb_reg_we;
  logic [XLEN-1:0]       wb_reg_wdata;
  logic                  rec_valid;
  logic [XLEN-1:0]       rec_pc;
  logic [XLEN-1:0]       rec_instr;
  instr_class_t          rec_class;
  logic [31:0]           rec_cycle;
  logic [REG_ADDR_W-1:0] rec_rd;
  logic                  rec_rd_written;
  logic [XLEN-1:0]       rec_rd_wdata;
  logic                  rec_mem_valid;
  logic                  rec_mem_we;
  logic [XLEN-1:0]       rec_mem_addr;

  // core model state
  op_t         ops[$];
  op_t         ex_op;
  op_t         wb_op;
  logic [31:0] ex_pc;
  logic [31:0] wb_pc;
  logic [31:0] next_pc;
  logic        ex_busy;
  logic        wb_busy;
  logic        ex_granted;
  int          ex_wait;
  int          wb_wait;
  int unsigned issued;
  int unsigned rec_cnt;
  int unsigned err_cnt;

  instr_tracer #(.CYCLE_W(32)) i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst_n && rec_valid) begin
      rec_cnt <= rec_cnt + 1;
    end
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////
  task automatic add_op(input logic [31:0] word, input logic writer, input logic mem,
                        input logic store);
    ops.push_back({word, writer, mem, store});
  endtask

  // every class plus the invalid funct cases
  task automatic load_op_table();
    add_op(32'h0000_0013, 1'b0, 1'b0, 1'b0);
    add_op(32'h0001_22b7, 1'b1, 1'b0, 1'b0);
    add_op(32'h0000_1317, 1'b1, 1'b0, 1'b0);
    add_op(32'h0080_00ef, 1'b1, 1'b0, 1'b0);
    add_op(32'h0001_00e7, 1'b1, 1'b0, 1'b0);
    add_op(32'h0020_8463, 1'b0, 1'b0, 1'b0);
    add_op(32'h0013_8393, 1'b1, 1'b0, 1'b0);
    add_op(32'h0020_81b3, 1'b1, 1'b0, 1'b0);
    add_op(32'h4020_81b3, 1'b1, 1'b0, 1'b0);
    add_op(32'h0001_2203, 1'b1, 1'b1, 1'b0);
    add_op(32'h0001_4203, 1'b1, 1'b1, 1'b0);
    add_op(32'h0051_2023, 1'b0, 1'b1, 1'b1);
    add_op(32'h0ff0_000f, 1'b0, 1'b0, 1'b0);
    add_op(32'h0000_0073, 1'b0, 1'b0, 1'b0);
    // invalid ld, load funct3 7, store funct3 3, mul and a custom opcode
    add_op(32'h0001_3203, 1'b0, 1'b0, 1'b0);
    add_op(32'h0001_7203, 1'b0, 1'b0, 1'b0);
    add_op(32'h0051_3023, 1'b0, 1'b0, 1'b0);
    // the core still writes rd for mul
    add_op(32'h0220_81b3, 1'b1, 1'b0, 1'b0);
    add_op(32'h0000_007b, 1'b0, 1'b0, 1'b0);
  endtask

  // rd when the table marks a writer, else the neighbour register
  function automatic logic [REG_ADDR_W-1:0] write_target(input op_t op);
    if (op.writer) begin
      return op.word[11:7];
    end
    return op.word[11:7] ^ 5'd1;
  endfunction

  task automatic drive_idle();
    id_valid    <= 1'b0;
    is_decoding <= 1'b0;
    pipe_flush  <= 1'b0;
    ex_valid    <= 1'b0;
    ex_reg_we   <= 1'b0;
    ex_data_req <= 1'b0;
    ex_data_gnt <= 1'b0;
    wb_valid    <= 1'b0;
    wb_reg_we   <= 1'b0;
  endtask

  //////////////////////////////
  // in-order core with one slot per stage
  //////////////////////////////
  task automatic run_core();
    int k;
    ex_busy = 1'b0;
    wb_busy = 1'b0;
    next_pc = 32'h100;
    while (issued < N_INSTR || ex_busy || wb_busy) begin
      @(posedge clk);
      drive_idle();
      if (wb_busy) begin
        wb_reg_we    <= 1'b1;
        wb_reg_addr  <= write_target(wb_op);
        wb_reg_wdata <= wb_pc + 32'd1;
        if (wb_wait > 0) begin
          wb_wait--;
        end else begin
          wb_valid <= 1'b1;
          wb_busy = 1'b0;
        end
      end
      if (ex_busy) begin
        ex_reg_we    <= 1'b1;
        ex_reg_addr  <= write_target(ex_op);
        ex_reg_wdata <= ex_pc + 32'd2;
        // always grant the first access and sometimes a second
        if (ex_op.mem && (!ex_granted || $urandom_range(1, 0) == 1)) begin
          ex_data_req  <= 1'b1;
          ex_data_gnt  <= 1'b1;
          ex_data_we   <= ex_op.store;
          ex_data_addr <= ex_granted ? ex_pc + 32'd8 : ex_pc + 32'd4;
          ex_granted = 1'b1;
        end
        if (ex_wait > 0) begin
          ex_wait--;
        end else if (!wb_busy) begin
          ex_valid <= 1'b1;
          wb_op   = ex_op;
          wb_pc   = ex_pc;
          wb_wait = $urandom_range(2, 0);
          wb_busy = 1'b1;
          ex_busy = 1'b0;
        end
      end
      if (issued < N_INSTR && !ex_busy) begin
        k          = $urandom_range(ops.size() - 1, 0);
        ex_op      = ops[k];
        ex_pc      = next_pc;
        next_pc    = next_pc + 32'd4;
        ex_wait    = $urandom_range(2, 0);
        ex_granted = 1'b0;
        ex_busy    = 1'b1;
        issued++;
        pc    <= ex_pc;
        instr <= ex_op.word;
        // a flush also counts as issue
        if ($urandom_range(7, 0) == 0) begin
          pipe_flush <= 1'b1;
        end else begin
          id_valid    <= 1'b1;
          is_decoding <= 1'b1;
        end
      // either half of the issue condition alone must not issue
      end else if ($urandom_range(1, 0) == 1) begin
        id_valid <= 1'b1;
      end else begin
        is_decoding <= 1'b1;
      end
    end
    @(posedge clk);
    drive_idle();
  endtask

  task automatic report_result();
    int wait_cycles;
    wait_cycles = 0;
    while (rec_cnt != issued && wait_cycles < 20) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (rec_cnt != issued) begin
      err_cnt++;
      $display("Fail %0t: %0d records for %0d issues", $time, rec_cnt, issued);
    end
    $display("issues %0d, records %0d, errors %0d, assertion failures %0d",
             issued, rec_cnt, err_cnt, i_dut.u_props.fail_cnt);
    if (err_cnt == 0 && i_dut.u_props.fail_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  initial begin
    void'($urandom(SEED));
    issued       = 0;
    rec_cnt      = 0;
    err_cnt      = 0;
    rst_n        = 1'b0;
    pc           = '0;
    instr        = '0;
    id_valid     = 1'b0;
    is_decoding  = 1'b0;
    pipe_flush   = 1'b0;
    ex_valid     = 1'b0;
    ex_reg_addr  = '0;
    ex_reg_we    = 1'b0;
    ex_reg_wdata = '0;
    ex_data_req  = 1'b0;
    ex_data_gnt  = 1'b0;
    ex_data_we   = 1'b0;
    ex_data_addr = '0;
    wb_valid     = 1'b0;
    wb_reg_addr  = '0;
    wb_reg_we    = 1'b0;
    wb_reg_wdata = '0;
    load_op_table();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    run_core();
    report_result();
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, run did not complete", TIMEOUT_NS);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: instr_tracer_properties.sv
//////////////////////////////
// instr_tracer_properties
// concurrent checks on every trace record
// bound into instr_tracer
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module instr_tracer_properties #(
  parameter int CYCLE_W = trace_pkg::CYCLE_W_DEFAULT
) (
  input logic                             clk,
  input logic                             rst_n,
  input logic [trace_pkg::XLEN-1:0]       pc,
  input logic [trace_pkg::XLEN-1:0]       instr,
  input logic                             id_valid,
  input logic                             is_decoding,
  input logic                             pipe_flush,
  input logic                             ex_valid,
  input logic                             wb_valid,
  input logic                             rec_valid,
  input logic [trace_pkg::XLEN-1:0]       rec_pc,
  input logic [trace_pkg::XLEN-1:0]       rec_instr,
  input trace_pkg::instr_class_t          rec_class,
  input logic [CYCLE_W-1:0]               rec_cycle,
  input logic [trace_pkg::REG_ADDR_W-1:0] rec_rd,
  input logic                             rec_rd_written,
  input logic [trace_pkg::XLEN-1:0]       rec_rd_wdata,
  input logic                             rec_mem_valid,
  input logic                             rec_mem_we,
  input logic [trace_pkg::XLEN-1:0]       rec_mem_addr
);

  import trace_pkg::*;

  int unsigned        fail_cnt = 0;
  logic               issue;
  logic               ex_busy;
  logic               wb_busy;
  logic               seen_rec;
  logic [1:0]         wr_ptr;
  logic [1:0]         rd_ptr;
  logic [XLEN-1:0]    issue_pc_q [4];
  logic [XLEN-1:0]    issue_instr_q [4];
  logic [XLEN-1:0]    last_pc;
  logic [CYCLE_W-1:0] last_cycle;

  function automatic instr_class_t expected_class(input logic [XLEN-1:0] w);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = w[14:12];
    f7 = w[31:25];
    if (w == INSTR_NOP) begin
      return CLS_NOP;
    end
    case (w[6:0])
      OPC_LUI:    return CLS_LUI;
      OPC_AUIPC:  return CLS_AUIPC;
      OPC_JAL:    return CLS_JAL;
      OPC_JALR:   return CLS_JALR;
      OPC_BRANCH: return CLS_BRANCH;
      OPC_OPIMM:  return CLS_OPIMM;
      OPC_FENCE:  return CLS_FENCE;
      OPC_SYSTEM: return CLS_SYSTEM;
      OPC_LOAD:   return (f3 inside {3'd3, 3'd6, 3'd7}) ? CLS_INVALID : CLS_LOAD;
      OPC_STORE:  return (f3 < 3'd3) ? CLS_STORE : CLS_INVALID;
      OPC_OP:     return (f7 inside {7'h00, 7'h20}) ? CLS_OP : CLS_INVALID;
      default:    return CLS_INVALID;
    endcase
  endfunction

  function automatic logic writes_dest(input instr_class_t c);
    return c inside {CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_OPIMM, CLS_OP, CLS_LOAD};
  endfunction

  //////////////////////////////
  // issue order and stage occupancy
  //////////////////////////////
  assign issue = (id_valid && is_decoding) || pipe_flush;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_busy    <= 1'b0;
      wb_busy    <= 1'b0;
      seen_rec   <= 1'b0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      last_pc    <= '0;
      last_cycle <= '0;
    end else begin
      ex_busy <= issue || (ex_busy && !ex_valid);
      wb_busy <= (ex_busy && ex_valid) || (wb_busy && !wb_valid);
      if (issue) begin
        wr_ptr <= wr_ptr + 2'd1;
      end
      if (rec_valid) begin
        rd_ptr     <= rd_ptr + 2'd1;
        seen_rec   <= 1'b1;
        last_pc    <= rec_pc;
        last_cycle <= rec_cycle;
      end
    end
  end

  // up to three instructions between issue and record
  always_ff @(posedge clk) begin
    if (issue) begin
      issue_pc_q[wr_ptr]    <= pc;
      issue_instr_q[wr_ptr] <= instr;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////
  a_reset_quiet: assert property (@(posedge clk)
    (!rst_n || $rose(rst_n)) |-> !rec_valid)
    else begin
      $error("record strobe during or right after reset");
      fail_cnt++;
    end

  a_ex_free: assert property (@(posedge clk) disable iff (!rst_n)
    (issue && ex_busy) |-> ex_valid)
    else begin
      $error("issue into an occupied EX slot");
      fail_cnt++;
    end

  a_wb_free: assert property (@(posedge clk) disable iff (!rst_n)
    (ex_valid && ex_busy && wb_busy) |-> wb_valid)
    else begin
      $error("EX handoff into an occupied WB slot");
      fail_cnt++;
    end

  a_class: assert property (@(posedge clk) disable iff (!rst_n)
    rec_valid |-> rec_class == expected_class(rec_instr))
    else begin
      $error("record class does not match its instruction word");
      fail_cnt++;
    end

  a_order: assert property (@(posedge clk) disable iff (!rst_n)
    rec_valid |-> (rec_pc == issue_pc_q[rd_ptr]) && (rec_instr == issue_instr_q[rd_ptr]) &&
                  (!seen_rec || rec_pc == last_pc + 32'd4))
    else begin
      $error("record pc or word out of issue order");
      fail_cnt++;
    end

  // rd is the fixed RV32 field in bits 11 to 7
  a_rd_index: assert property (@(posedge clk) disable iff (!rst_n)
    rec_valid |-> rec_rd == rec_instr[11:7])
    else begin
      $error("record rd does not match its instruction word");
      fail_cnt++;
    end

  a_rd: assert property (@(posedge clk) disable iff (!rst_n)
    rec_valid |-> (writes_dest(rec_class) ?
                   (rec_rd_written && rec_rd_wdata == rec_pc + 32'd1) : !rec_rd_written))
    else begin
      $error("destination write in record is wrong");
      fail_cnt++;
    end

  a_mem: assert property (@(posedge clk) disable iff (!rst_n)
    rec_valid |-> (rec_mem_valid == (rec_class inside {CLS_LOAD, CLS_STORE})) &&
                  (!rec_mem_valid || (rec_mem_addr == rec_pc + 32'd4 &&
                                      rec_mem_we == (rec_class == CLS_STORE))))
    else begin
      $error("data access in record is wrong");
      fail_cnt++;
    end

  a_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    (rec_valid && seen_rec) |-> rec_cycle > last_cycle)
    else begin
      $error("record cycle stamp did not increase");
      fail_cnt++;
    end

endmodule

bind instr_tracer instr_tracer_properties #(.CYCLE_W(CYCLE_W)) u_props (.*);

`default_nettype wire

// File: instr_tracer.sv
//////////////////////////////
// instr_tracer top level
// issue -> EX tracking -> WB retirement
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module instr_tracer #(
  parameter int CYCLE_W = trace_pkg::CYCLE_W_DEFAULT
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [trace_pkg::XLEN-1:0]       pc,
  input  logic [trace_pkg::XLEN-1:0]       instr,
  input  logic                             id_valid,
  input  logic                             is_decoding,
  input  logic                             pipe_flush,
  input  logic                             ex_valid,
  input  logic [trace_pkg::REG_ADDR_W-1:0] ex_reg_addr,
  input  logic                             ex_reg_we,
  input  logic [trace_pkg::XLEN-1:0]       ex_reg_wdata,
  input  logic                             ex_data_req,
  input  logic                             ex_data_gnt,
  input  logic                             ex_data_we,
  input  logic [trace_pkg::XLEN-1:0]       ex_data_addr,
  input  logic                             wb_valid,
  input  logic [trace_pkg::REG_ADDR_W-1:0] wb_reg_addr,
  input  logic                             wb_reg_we,
  input  logic [trace_pkg::XLEN-1:0]       wb_reg_wdata,
  output logic                             rec_valid,
  output logic [trace_pkg::XLEN-1:0]       rec_pc,
  output logic [trace_pkg::XLEN-1:0]       rec_instr,
  output trace_pkg::instr_class_t          rec_class,
  output logic [CYCLE_W-1:0]               rec_cycle,
  output logic [trace_pkg::REG_ADDR_W-1:0] rec_rd,
  output logic                             rec_rd_written,
  output logic [trace_pkg::XLEN-1:0]       rec_rd_wdata,
  output logic                             rec_mem_valid,
  output logic                             rec_mem_we,
  output logic [trace_pkg::XLEN-1:0]       rec_mem_addr
);

  import trace_pkg::*;

  // issue to EX slot
  logic                  ex_entry_load;
  logic [XLEN-1:0]       ex_entry_pc;
  logic [XLEN-1:0]       ex_entry_instr;
  instr_class_t          ex_entry_class;
  logic [REG_ADDR_W-1:0] ex_entry_rd;
  logic                  ex_entry_writes_rd;
  logic [CYCLE_W-1:0]    ex_entry_cycle;

  // EX slot to WB slot
  logic                  wb_entry_load;
  logic [XLEN-1:0]       wb_entry_pc;
  logic [XLEN-1:0]       wb_entry_instr;
  instr_class_t          wb_entry_class;
  logic [REG_ADDR_W-1:0] wb_entry_rd;
  logic                  wb_entry_writes_rd;
  logic [CYCLE_W-1:0]    wb_entry_cycle;
  logic                  wb_entry_rd_written;
  logic [XLEN-1:0]       wb_entry_rd_wdata;
  logic                  wb_entry_mem_valid;
  logic                  wb_entry_mem_we;
  logic [XLEN-1:0]       wb_entry_mem_addr;

  // port names match the nets above one to one
  trace_issue #(.CYCLE_W(CYCLE_W)) u_issue (.*);

  trace_ex_track #(.CYCLE_W(CYCLE_W)) u_ex_track (.*);

  trace_wb_retire #(.CYCLE_W(CYCLE_W)) u_wb_retire (.*);

endmodule

`default_nettype wire

// File: trace_wb_retire.sv
//////////////////////////////
// trace_wb_retire
// single WB slot with writeback override
// and the registered trace record
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module trace_wb_retire #(
  parameter int CYCLE_W = trace_pkg::CYCLE_W_DEFAULT
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             wb_entry_load,
  input  logic [trace_pkg::XLEN-1:0]       wb_entry_pc,
  input  logic [trace_pkg::XLEN-1:0]       wb_entry_instr,
  input  trace_pkg::instr_class_t          wb_entry_class,
  input  logic [trace_pkg::REG_ADDR_W-1:0] wb_entry_rd,
  input  logic                             wb_entry_writes_rd,
  input  logic [CYCLE_W-1:0]               wb_entry_cycle,
  input  logic                             wb_entry_rd_written,
  input  logic [trace_pkg::XLEN-1:0]       wb_entry_rd_wdata,
  input  logic                             wb_entry_mem_valid,
  input  logic                             wb_entry_mem_we,
  input  logic [trace_pkg::XLEN-1:0]       wb_entry_mem_addr,
  input  logic                             wb_valid,
  input  logic [trace_pkg::REG_ADDR_W-1:0] wb_reg_addr,
  input  logic                             wb_reg_we,
  input  logic [trace_pkg::XLEN-1:0]       wb_reg_wdata,
  output logic                             rec_valid,
  output logic [trace_pkg::XLEN-1:0]       rec_pc,
  output logic [trace_pkg::XLEN-1:0]       rec_instr,
  output trace_pkg::instr_class_t          rec_class,
  output logic [CYCLE_W-1:0]               rec_cycle,
  output logic [trace_pkg::REG_ADDR_W-1:0] rec_rd,
  output logic                             rec_rd_written,
  output logic [trace_pkg::XLEN-1:0]       rec_rd_wdata,
  output logic                             rec_mem_valid,
  output logic                             rec_mem_we,
  output logic [trace_pkg::XLEN-1:0]       rec_mem_addr
);

  import trace_pkg::*;

  logic                  slot_occ;
  logic [XLEN-1:0]       slot_pc;
  logic [XLEN-1:0]       slot_instr;
  instr_class_t          slot_class;
  logic [REG_ADDR_W-1:0] slot_rd;
  logic                  slot_writes_rd;
  logic [CYCLE_W-1:0]    slot_cycle;
  logic                  slot_rd_written;
  logic [XLEN-1:0]       slot_rd_wdata;
  logic                  slot_mem_valid;
  logic                  slot_mem_we;
  logic [XLEN-1:0]       slot_mem_addr;
  logic                  wb_hit;
  logic                  retire;

  // a later writeback replaces the EX value
  assign wb_hit = slot_occ && slot_writes_rd && wb_reg_we && (wb_reg_addr == slot_rd);
  assign retire = slot_occ && wb_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_occ  <= 1'b0;
      rec_valid <= 1'b0;
    end else begin
      slot_occ  <= wb_entry_load || (slot_occ && !wb_valid);
      rec_valid <= retire;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_entry_load) begin
      slot_pc         <= wb_entry_pc;
      slot_instr      <= wb_entry_instr;
      slot_class      <= wb_entry_class;
      slot_rd         <= wb_entry_rd;
      slot_writes_rd  <= wb_entry_writes_rd;
      slot_cycle      <= wb_entry_cycle;
      slot_rd_written <= wb_entry_rd_written;
      slot_rd_wdata   <= wb_entry_rd_wdata;
      slot_mem_valid  <= wb_entry_mem_valid;
      slot_mem_we     <= wb_entry_mem_we;
      slot_mem_addr   <= wb_entry_mem_addr;
    end else if (wb_hit) begin
      slot_rd_written <= 1'b1;
      slot_rd_wdata   <= wb_reg_wdata;
    end
  end

  //////////////////////////////
  // record, valid one cycle after retire
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (retire) begin
      rec_pc         <= slot_pc;
      rec_instr      <= slot_instr;
      rec_class      <= slot_class;
      rec_cycle      <= slot_cycle;
      rec_rd         <= slot_rd;
      rec_rd_written <= slot_rd_written || wb_hit;
      rec_rd_wdata   <= wb_hit ? wb_reg_wdata : slot_rd_wdata;
      rec_mem_valid  <= slot_mem_valid;
      rec_mem_we     <= slot_mem_we;
      rec_mem_addr   <= slot_mem_addr;
    end
  end

endmodule

`default_nettype wire

// File: trace_ex_track.sv
//////////////////////////////
// trace_ex_track
// single EX slot, merges rd writes and
// the first data grant, hands off to WB
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module trace_ex_track #(
  parameter int CYCLE_W = trace_pkg::CYCLE_W_DEFAULT
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             ex_entry_load,
  input  logic [trace_pkg::XLEN-1:0]       ex_entry_pc,
  input  logic [trace_pkg::XLEN-1:0]       ex_entry_instr,
  input  trace_pkg::instr_class_t          ex_entry_class,
  input  logic [trace_pkg::REG_ADDR_W-1:0] ex_entry_rd,
  input  logic                             ex_entry_writes_rd,
  input  logic [CYCLE_W-1:0]               ex_entry_cycle,
  input  logic                             ex_valid,
  input  logic [trace_pkg::REG_ADDR_W-1:0] ex_reg_addr,
  input  logic                             ex_reg_we,
  input  logic [trace_pkg::XLEN-1:0]       ex_reg_wdata,
  input  logic                             ex_data_req,
  input  logic                             ex_data_gnt,
  input  logic                             ex_data_we,
  input  logic [trace_pkg::XLEN-1:0]       ex_data_addr,
  output logic                             wb_entry_load,
  output logic [trace_pkg::XLEN-1:0]       wb_entry_pc,
  output logic [trace_pkg::XLEN-1:0]       wb_entry_instr,
  output trace_pkg::instr_class_t          wb_entry_class,
  output logic [trace_pkg::REG_ADDR_W-1:0] wb_entry_rd,
  output logic                             wb_entry_writes_rd,
  output logic [CYCLE_W-1:0]               wb_entry_cycle,
  output logic                             wb_entry_rd_written,
  output logic [trace_pkg::XLEN-1:0]       wb_entry_rd_wdata,
  output logic                             wb_entry_mem_valid,
  output logic                             wb_entry_mem_we,
  output logic [trace_pkg::XLEN-1:0]       wb_entry_mem_addr
);

  import trace_pkg::*;

  logic                  slot_occ;
  logic [XLEN-1:0]       slot_pc;
  logic [XLEN-1:0]       slot_instr;
  instr_class_t          slot_class;
  logic [REG_ADDR_W-1:0] slot_rd;
  logic                  slot_writes_rd;
  logic [CYCLE_W-1:0]    slot_cycle;
  logic                  slot_rd_written;
  logic [XLEN-1:0]       slot_rd_wdata;
  logic                  slot_mem_valid;
  logic                  slot_mem_we;
  logic [XLEN-1:0]       slot_mem_addr;
  logic                  reg_hit;
  logic                  mem_hit;

  // updates seen at this edge
  assign reg_hit = slot_occ && slot_writes_rd && ex_reg_we && (ex_reg_addr == slot_rd);
  assign mem_hit = slot_occ && !slot_mem_valid && ex_data_req && ex_data_gnt;

  //////////////////////////////
  // merged entry towards WB
  //////////////////////////////
  assign wb_entry_load       = slot_occ && ex_valid;
  assign wb_entry_pc         = slot_pc;
  assign wb_entry_instr      = slot_instr;
  assign wb_entry_class      = slot_class;
  assign wb_entry_rd         = slot_rd;
  assign wb_entry_writes_rd  = slot_writes_rd;
  assign wb_entry_cycle      = slot_cycle;
  assign wb_entry_rd_written = slot_rd_written || reg_hit;
  assign wb_entry_rd_wdata   = reg_hit ? ex_reg_wdata : slot_rd_wdata;
  assign wb_entry_mem_valid  = slot_mem_valid || mem_hit;
  assign wb_entry_mem_we     = mem_hit ? ex_data_we : slot_mem_we;
  assign wb_entry_mem_addr   = mem_hit ? ex_data_addr : slot_mem_addr;

  // occupancy and capture flags, a new issue wins over release
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_occ        <= 1'b0;
      slot_rd_written <= 1'b0;
      slot_mem_valid  <= 1'b0;
    end else if (ex_entry_load) begin
      slot_occ        <= 1'b1;
      slot_rd_written <= 1'b0;
      slot_mem_valid  <= 1'b0;
    end else begin
      slot_occ        <= slot_occ && !ex_valid;
      slot_rd_written <= wb_entry_rd_written;
      slot_mem_valid  <= wb_entry_mem_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_entry_load) begin
      slot_pc        <= ex_entry_pc;
      slot_instr     <= ex_entry_instr;
      slot_class     <= ex_entry_class;
      slot_rd        <= ex_entry_rd;
      slot_writes_rd <= ex_entry_writes_rd;
      slot_cycle     <= ex_entry_cycle;
    end else begin
      slot_rd_wdata <= wb_entry_rd_wdata;
      slot_mem_we   <= wb_entry_mem_we;
      slot_mem_addr <= wb_entry_mem_addr;
    end
  end

endmodule

`default_nettype wire

// File: trace_issue.sv
//////////////////////////////
// trace_issue
// free running cycle counter
// issue detection and EX entry fields
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module trace_issue #(
  parameter int CYCLE_W = trace_pkg::CYCLE_W_DEFAULT
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [trace_pkg::XLEN-1:0]       pc,
  input  logic [trace_pkg::XLEN-1:0]       instr,
  input  logic                             id_valid,
  input  logic                             is_decoding,
  input  logic                             pipe_flush,
  output logic                             ex_entry_load,
  output logic [trace_pkg::XLEN-1:0]       ex_entry_pc,
  output logic [trace_pkg::XLEN-1:0]       ex_entry_instr,
  output trace_pkg::instr_class_t          ex_entry_class,
  output logic [trace_pkg::REG_ADDR_W-1:0] ex_entry_rd,
  output logic                             ex_entry_writes_rd,
  output logic [CYCLE_W-1:0]               ex_entry_cycle
);

  import trace_pkg::*;

  logic [CYCLE_W-1:0] cycle_cnt;

  // counts every edge and simply wraps
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  // a flush also retires whatever sits in decode
  assign ex_entry_load = (id_valid && is_decoding) || pipe_flush;

  assign ex_entry_pc    = pc;
  assign ex_entry_instr = instr;
  assign ex_entry_rd    = instr[7 +: REG_ADDR_W];
  // stamp is the count before this edge's increment
  assign ex_entry_cycle = cycle_cnt;

  trace_decoder u_decoder (
    .instr       (instr),
    .instr_class (ex_entry_class),
    .writes_rd   (ex_entry_writes_rd)
  );

endmodule

`default_nettype wire

// File: trace_decoder.sv
//////////////////////////////
// trace_decoder
// sorts an instruction word into its class
// and flags destination register use
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module trace_decoder (
  input  logic [trace_pkg::XLEN-1:0] instr,
  output trace_pkg::instr_class_t    instr_class,
  output logic                       writes_rd
);

  import trace_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    instr_class = CLS_INVALID;
    // canonical nop takes precedence over OPIMM
    if (instr == INSTR_NOP) begin
      instr_class = CLS_NOP;
    end else begin
      case (opcode)
        OPC_LUI:    instr_class = CLS_LUI;
        OPC_AUIPC:  instr_class = CLS_AUIPC;
        OPC_JAL:    instr_class = CLS_JAL;
        OPC_JALR:   instr_class = CLS_JALR;
        OPC_BRANCH: instr_class = CLS_BRANCH;
        OPC_OPIMM:  instr_class = CLS_OPIMM;
        OPC_FENCE:  instr_class = CLS_FENCE;
        OPC_SYSTEM: instr_class = CLS_SYSTEM;
        // lb lh lw lbu lhu only
        OPC_LOAD: begin
          if (funct3 == 3'd3 || funct3 >= 3'd6) begin
            instr_class = CLS_INVALID;
          end else begin
            instr_class = CLS_LOAD;
          end
        end
        // sb sh sw only
        OPC_STORE: begin
          if (funct3 >= 3'd3) begin
            instr_class = CLS_INVALID;
          end else begin
            instr_class = CLS_STORE;
          end
        end
        // base ALU ops, sub and sra use 0x20
        OPC_OP: begin
          if (funct7 == 7'h00 || funct7 == 7'h20) begin
            instr_class = CLS_OP;
          end else begin
            instr_class = CLS_INVALID;
          end
        end
        default: instr_class = CLS_INVALID;
      endcase
    end
  end

  // classes that produce a result in rd
  assign writes_rd = instr_class inside {CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR,
                                         CLS_OPIMM, CLS_OP, CLS_LOAD};

endmodule

`default_nettype wire

// File: trace_pkg.sv
//////////////////////////////
// instruction tracer shared definitions
// data, register and cycle widths
// RV32 major opcodes and the nop word
// instruction class enumeration
//////////////////////////////

`default_nettype none

package trace_pkg;

  // datapath widths
  localparam int XLEN            = 32;
  localparam int REG_ADDR_W      = 5;
  localparam int CYCLE_W_DEFAULT = 32;

  //////////////////////////////
  // major opcodes
  //////////////////////////////
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_FENCE  = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // addi x0, x0, 0
  localparam logic [XLEN-1:0] INSTR_NOP = 32'h0000_0013;

  //////////////////////////////
  // instruction classes
  //////////////////////////////
  typedef enum logic [3:0] {
    CLS_NOP     = 4'd0,
    CLS_LUI     = 4'd1,
    CLS_AUIPC   = 4'd2,
    CLS_JAL     = 4'd3,
    CLS_JALR    = 4'd4,
    CLS_BRANCH  = 4'd5,
    CLS_OPIMM   = 4'd6,
    CLS_OP      = 4'd7,
    CLS_LOAD    = 4'd8,
    CLS_STORE   = 4'd9,
    CLS_FENCE   = 4'd10,
    CLS_SYSTEM  = 4'd11,
    CLS_INVALID = 4'd12
  } instr_class_t;

endpackage

`default_nettype wire
